// ==== tests/cart_bus_patterns.txt ====
# op       addr    data  expect   (all values hex)
# the data column is the write byte, or the romsel_n level for snes_rd
cpu_stop   000000  00    00
mcu_wr     000100  a5    a5
mcu_rd     000100  00    a5
mcu_wr     000201  3c    3c
mcu_wr     000200  c7    c7
mcu_rd     000201  00    3c
mcu_rd     000200  00    c7
cpu_run    000000  00    00
mcu_wr     000123  5e    5e
mcu_wr     000122  81    81
mcu_rd     000123  00    5e
mcu_rd     000122  00    81
mcu_rd     000100  00    a5
snes_rd    c0a123  00    5e
snes_rd    7fe122  00    81
snes_rd    c0a123  01    00
cpu_stop   000000  00    00
mcu_wr     001fff  69    69
mcu_rd     001fff  00    69
mcu_rd     000201  00    3c

// ==== vlog.f ====
design/snes_bus_pkg.sv
design/psram_pkg.sv
design/snes_bus_sampler.sv
design/mcu_access_fsm.sv
design/psram_port_mux.sv
design/cart_bus_top.sv
tests/tb_cart_bus.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the cart bus testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_cart_bus -f vlog.f \
  && ./obj_dir/Vtb_cart_bus > sim.log 2>&1 \
  || { echo "build or simulation error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "^TESTBENCH PASSED$" sim.log && exit 0 || exit 1

// ==== tests/tb_cart_bus.sv ====
module tb_cart_bus;
  timeunit 1ns;
  timeprecision 100ps;

  import snes_bus_pkg::*;
  import psram_pkg::*;

  localparam int timeout_cycles = 1000;
  localparam int dead_cycles    = 200;

  logic        CLK2;
  logic        arst_n;
  snes_addr_t  rom_mask;
  snes_addr_t  snes_addr;
  logic        snes_read_n;
  logic        snes_romsel_n;
  logic        snes_cpu_clk;
  snes_byte_t  snes_data_out;
  logic        snes_data_oe;
  logic        databus_oe_n;
  mcu_req_t    mcu_req;
  snes_byte_t  mcu_rdata;
  logic        mcu_rdy;
  psram_addr_t rom_addr;
  psram_word_t rom_data_in;
  psram_word_t rom_data_out;
  logic        rom_data_oe;
  logic        rom_we_n;
  logic        rom_bhe_n;
  logic        rom_ble_n;

  // state shared with the console process
  logic       cpu_running = 1'b0;
  int         rd_reqs     = 0;
  int         rd_served   = 0;
  snes_addr_t rd_addr_q;
  logic       rd_romsel_q;
  snes_byte_t seen_data;
  logic       seen_oe;
  logic       seen_oe_n;

  logic timed_out = 1'b0;
  logic test_ok;
  int   tests_run;
  int   tests_failed;

  cart_bus_top #(
    .dead_timeout  (dead_cycles),
    .rom_cycle_len (7)
  ) i_dut (.*);

  initial begin
    CLK2 = 1'b0;
    forever #10 CLK2 = ~CLK2;
  end

  //////////////////////////////
  // PSRAM model
  //////////////////////////////

  psram_word_t mem [4096];

  assign rom_data_in = mem[rom_addr[11:0]];

  always @(posedge CLK2) begin
    if (!arst_n) begin
      // fill pattern from the full word index
      for (int i = 0; i < 4096; i++) begin
        mem[i] <= 16'(i * 40503 + 4660);
      end
    end else if (!rom_we_n) begin
      // undriven write data lands as unknown
      if (!rom_bhe_n) begin
        mem[rom_addr[11:0]][15:8] <= rom_data_oe ? rom_data_out[15:8] : 8'hxx;
      end
      if (!rom_ble_n) begin
        mem[rom_addr[11:0]][7:0] <= rom_data_oe ? rom_data_out[7:0] : 8'hxx;
      end
    end
  end

  // odd byte addresses live in bits 7:0 of the word
  function automatic snes_byte_t model_byte(input snes_addr_t addr);
    psram_word_t word;
    word = mem[addr[12:1]];
    return addr[0] ? word[7:0] : word[15:8];
  endfunction

  //////////////////////////////
  // console bus
  //////////////////////////////

  // clock low for a random gap and then high long enough for a cycle_end
  task automatic console_cycle(input snes_addr_t addr, input logic romsel_n,
                               input logic read_n);
    int low_len;
    low_len       = 6 + int'($urandom % 4);
    snes_addr     = addr;
    snes_romsel_n = romsel_n;
    snes_read_n   = read_n;
    snes_cpu_clk  = 1'b0;
    repeat (low_len) begin
      @(posedge CLK2);
      #2;
    end
    snes_cpu_clk = 1'b1;
    repeat (6) begin
      @(posedge CLK2);
      #2;
    end
    // all sampler pipelines have settled by now
    seen_data     = snes_data_out;
    seen_oe       = snes_data_oe;
    seen_oe_n     = databus_oe_n;
    snes_read_n   = 1'b1;
    snes_romsel_n = 1'b1;
  endtask

  initial begin : console_bus
    snes_addr     = '0;
    snes_read_n   = 1'b1;
    snes_romsel_n = 1'b1;
    snes_cpu_clk  = 1'b0;
    forever begin
      if (rd_served != rd_reqs) begin
        console_cycle(rd_addr_q, rd_romsel_q, 1'b0);
        rd_served++;
      end else if (cpu_running) begin
        console_cycle('0, 1'b1, 1'b1);
      end else begin
        snes_cpu_clk = 1'b0;
        @(posedge CLK2);
        #2;
      end
    end
  end

  //////////////////////////////
  // checks and operations
  //////////////////////////////

  task automatic check_byte(input string name, input snes_byte_t exp, input snes_byte_t act);
    assert (act === exp) else begin
      $display("FAILED %s expected %02h actual %02h", name, exp, act);
      test_ok = 1'b0;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_ok) begin
      $display("ok   %s", name);
    end else begin
      tests_failed++;
      $display("fail %s", name);
    end
  endtask

  task automatic wait_ready(input string name);
    int cycles;
    cycles = 0;
    while (!mcu_rdy && cycles < timeout_cycles) begin
      @(posedge CLK2);
      #2;
      cycles++;
    end
    assert (mcu_rdy) else begin
      $display("ERROR: %s, mcu_rdy did not return within %0d cycles", name, timeout_cycles);
      test_ok   = 1'b0;
      timed_out = 1'b1;
    end
  endtask

  // one request pulse with the write data held until ready returns
  task automatic mcu_access(input string name, input logic is_write,
                            input snes_addr_t addr, input snes_byte_t data);
    wait_ready(name);
    mcu_req.addr  = addr;
    mcu_req.wdata = data;
    mcu_req.rrq   = ~is_write;
    mcu_req.wrq   = is_write;
    @(posedge CLK2);
    #2;
    mcu_req.rrq = 1'b0;
    mcu_req.wrq = 1'b0;
    assert (!mcu_rdy) else begin
      $display("ERROR: %s, mcu_rdy stayed high after the request pulse", name);
      test_ok = 1'b0;
    end
    wait_ready(name);
  endtask

  task automatic console_read(input string name, input snes_addr_t addr, input logic romsel_n);
    int cycles;
    rd_addr_q   = addr;
    rd_romsel_q = romsel_n;
    rd_reqs++;
    cycles = 0;
    while (rd_served != rd_reqs && cycles < timeout_cycles) begin
      @(posedge CLK2);
      #2;
      cycles++;
    end
    assert (rd_served == rd_reqs) else begin
      $display("ERROR: %s, console read cycle did not finish in time", name);
      test_ok   = 1'b0;
      timed_out = 1'b1;
    end
  endtask

  task automatic run_pattern(input int line_no, input logic [63:0] op_name,
                             input snes_addr_t addr, input snes_byte_t data,
                             input snes_byte_t exp);
    string name;
    test_ok = 1'b1;
    case (op_name)
      64'("mcu_wr"): begin
        name = $sformatf("line%0d_mcu_wr_%06h", line_no, addr);
        mcu_access(name, 1'b1, addr, data);
        check_byte(name, exp, model_byte(addr));
      end
      64'("mcu_rd"): begin
        name = $sformatf("line%0d_mcu_rd_%06h", line_no, addr);
        mcu_access(name, 1'b0, addr, 8'h00);
        check_byte(name, exp, mcu_rdata);
      end
      64'("snes_rd"): begin
        name = $sformatf("line%0d_snes_rd_%06h", line_no, addr);
        console_read(name, addr, data[0]);
        if (!data[0]) begin
          check_byte(name, exp, seen_data);
          check_byte({name, "_oe"}, 8'h01, {7'b0, seen_oe});
          check_byte({name, "_oe_n"}, 8'h00, {7'b0, seen_oe_n});
        end else begin
          // with romsel high the bus stays released
          check_byte({name, "_oe"}, 8'h00, {7'b0, seen_oe});
          check_byte({name, "_oe_n"}, 8'h01, {7'b0, seen_oe_n});
        end
      end
      64'("cpu_run"): begin
        name        = $sformatf("line%0d_cpu_run", line_no);
        cpu_running = 1'b1;
      end
      64'("cpu_stop"): begin
        name        = $sformatf("line%0d_cpu_stop", line_no);
        cpu_running = 1'b0;
      end
      default: begin
        name = $sformatf("line%0d_unknown", line_no);
        $display("ERROR: unknown operation on pattern line %0d", line_no);
        test_ok = 1'b0;
      end
    endcase
    finish_test(name);
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin : main_seq
    int              fd;
    int              line_no;
    int              fields;
    logic            file_ok;
    logic [8*96-1:0] line_buf;
    logic [63:0]     op_name;
    snes_addr_t      f_addr;
    snes_byte_t      f_data;
    snes_byte_t      f_exp;

    void'($urandom(71934));
    arst_n       = 1'b0;
    rom_mask     = 24'h001fff;
    mcu_req      = '0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (10) @(posedge CLK2);
    #2;
    arst_n = 1'b1;
    @(posedge CLK2);
    #2;

    test_ok = 1'b1;
    check_byte("reset_mcu_rdy", 8'h01, {7'b0, mcu_rdy});
    check_byte("reset_databus_oe_n", 8'h01, {7'b0, databus_oe_n});
    check_byte("reset_snes_data_oe", 8'h00, {7'b0, snes_data_oe});
    check_byte("reset_rom_data_oe", 8'h00, {7'b0, rom_data_oe});
    check_byte("reset_rom_we_n", 8'h01, {7'b0, rom_we_n});
    finish_test("reset_values");

    fd      = $fopen("tests/cart_bus_patterns.txt", "r");
    file_ok = (fd != 0);
    if (!file_ok) begin
      $display("ERROR: cannot open tests/cart_bus_patterns.txt");
    end
    line_no = 0;
    while (file_ok && !timed_out && !$feof(fd)) begin
      line_buf = '0;
      op_name  = '0;
      line_no++;
      if ($fgets(line_buf, fd) != 0) begin
        // comment and blank lines do not give four fields
        fields = $sscanf(line_buf, "%s %h %h %h", op_name, f_addr, f_data, f_exp);
        if (fields == 4) begin
          run_pattern(line_no, op_name, f_addr, f_data, f_exp);
        end
      end
    end
    if (file_ok) begin
      $fclose(fd);
    end

    $display("tests run %0d, failed %0d", tests_run, tests_failed);
    if (file_ok && !timed_out && tests_failed == 0 && tests_run > 1) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== design/cart_bus_top.sv ====
module cart_bus_top #(
  parameter int dead_timeout  = 96000,
  parameter int rom_cycle_len = 7
) (
  input  logic                     CLK2,
  input  logic                     arst_n,
  input  snes_bus_pkg::snes_addr_t rom_mask,
  input  snes_bus_pkg::snes_addr_t snes_addr,
  input  logic                     snes_read_n,
  input  logic                     snes_romsel_n,
  input  logic                     snes_cpu_clk,
  output snes_bus_pkg::snes_byte_t snes_data_out,
  output logic                     snes_data_oe,
  output logic                     databus_oe_n,
  input  psram_pkg::mcu_req_t      mcu_req,
  output snes_bus_pkg::snes_byte_t mcu_rdata,
  output logic                     mcu_rdy,
  output psram_pkg::psram_addr_t   rom_addr,
  input  psram_pkg::psram_word_t   rom_data_in,
  output psram_pkg::psram_word_t   rom_data_out,
  output logic                     rom_data_oe,
  output logic                     rom_we_n,
  output logic                     rom_bhe_n,
  output logic                     rom_ble_n
);
  import snes_bus_pkg::*;
  import psram_pkg::*;

  snes_view_t  view;
  mcu_access_t access;

  snes_bus_sampler #(
    .dead_timeout (dead_timeout)
  ) i_sampler (
    .CLK2          (CLK2),
    .arst_n        (arst_n),
    .snes_addr     (snes_addr),
    .snes_read_n   (snes_read_n),
    .snes_romsel_n (snes_romsel_n),
    .snes_cpu_clk  (snes_cpu_clk),
    .rom_mask      (rom_mask),
    .view          (view)
  );

  mcu_access_fsm #(
    .rom_cycle_len (rom_cycle_len)
  ) i_fsm (
    .CLK2    (CLK2),
    .arst_n  (arst_n),
    .req     (mcu_req),
    .view    (view),
    .access  (access),
    .mcu_rdy (mcu_rdy)
  );

  psram_port_mux i_mux (
    .CLK2          (CLK2),
    .arst_n        (arst_n),
    .view          (view),
    .access        (access),
    .mcu_wdata     (mcu_req.wdata),
    .rom_data_in   (rom_data_in),
    .rom_addr      (rom_addr),
    .rom_data_out  (rom_data_out),
    .rom_data_oe   (rom_data_oe),
    .rom_we_n      (rom_we_n),
    .rom_bhe_n     (rom_bhe_n),
    .rom_ble_n     (rom_ble_n),
    .snes_data_out (snes_data_out),
    .snes_data_oe  (snes_data_oe),
    .databus_oe_n  (databus_oe_n),
    .mcu_rdata     (mcu_rdata)
  );

endmodule

// ==== design/psram_port_mux.sv ====
module psram_port_mux (
  input  logic                     CLK2,
  input  logic                     arst_n,
  input  snes_bus_pkg::snes_view_t view,
  input  psram_pkg::mcu_access_t   access,
  input  snes_bus_pkg::snes_byte_t mcu_wdata,
  input  psram_pkg::psram_word_t   rom_data_in,
  output psram_pkg::psram_addr_t   rom_addr,
  output psram_pkg::psram_word_t   rom_data_out,
  output logic                     rom_data_oe,
  output logic                     rom_we_n,
  output logic                     rom_bhe_n,
  output logic                     rom_ble_n,
  output snes_bus_pkg::snes_byte_t snes_data_out,
  output logic                     snes_data_oe,
  output logic                     databus_oe_n,
  output snes_bus_pkg::snes_byte_t mcu_rdata
);
  import snes_bus_pkg::*;

  logic       mcu_hit;
  snes_addr_t sel_addr;
  logic       addr0;
  snes_byte_t lane_byte;
  logic       snes_rd;

  ////////////////////////////////
  // address and lane select
  ////////////////////////////////

  // MCU owns the PSRAM while it has an access running
  assign mcu_hit  = access.rd_active | access.wr_active;
  assign sel_addr = mcu_hit ? access.addr : view.rom_addr;
  assign addr0    = sel_addr[0];
  assign rom_addr = sel_addr[23:1];

  // odd byte in the low lane and even byte in the high lane
  assign lane_byte = addr0 ? rom_data_in[7:0] : rom_data_in[15:8];
  assign rom_ble_n = ~addr0;
  assign rom_bhe_n = addr0;

  ////////////////////////////////
  // write path
  ////////////////////////////////

  assign rom_we_n     = ~access.wr_active;
  assign rom_data_oe  = access.wr_active;
  assign rom_data_out = addr0 ? {8'h00, mcu_wdata} : {mcu_wdata, 8'h00};

  ////////////////////////////////
  // console and MCU read data
  ////////////////////////////////

  assign snes_rd       = view.rom_hit & ~view.read_n;
  assign snes_data_out = lane_byte;
  assign snes_data_oe  = snes_rd;
  // level converter enable is active low
  assign databus_oe_n  = ~snes_rd;

  // last sample of the address phase is the one the MCU keeps
  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      mcu_rdata <= '0;
    end else if (access.rd_active) begin
      mcu_rdata <= lane_byte;
    end
  end

  // an MCU write keeps its address still while the write strobe is low
  a_we_only_mcu_write: assert property (
    @(posedge CLK2) disable iff (!arst_n)
    !rom_we_n |-> access.wr_active && !access.rd_active && $stable(access.addr)
  );

endmodule

// ==== design/mcu_access_fsm.sv ====
module mcu_access_fsm #(
  parameter int rom_cycle_len = 7
) (
  input  logic                      CLK2,
  input  logic                      arst_n,
  input  psram_pkg::mcu_req_t       req,
  input  snes_bus_pkg::snes_view_t  view,
  output psram_pkg::mcu_access_t    access,
  output logic                      mcu_rdy
);
  import snes_bus_pkg::*;
  import psram_pkg::*;

  localparam int dly_w = $clog2(rom_cycle_len + 2);

  access_state_t    state;
  logic [dly_w-1:0] delay_cnt;
  logic             rd_pend;
  logic             wr_pend;
  snes_addr_t       addr_q;
  logic             access_done;

  assign access_done = (state == rd_end) || (state == wr_end);

  ////////////////////////////////
  // request capture
  ////////////////////////////////

  // pulses while busy are dropped
  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end else if (req.rrq && mcu_rdy) begin
      rd_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (req.wrq && mcu_rdy) begin
      wr_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (access_done) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end
  end

  always_ff @(posedge CLK2) begin
    if ((req.rrq || req.wrq) && mcu_rdy) begin
      addr_q <= req.addr;
    end
  end

  ////////////////////////////////
  // access sequencing
  ////////////////////////////////

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      state     <= idle;
      delay_cnt <= '0;
    end else if (view.revive) begin
      // console woke up so the access restarts in a later free slot
      state <= idle;
    end else begin
      case (state)
        idle: begin
          if (view.free_slot || view.dead) begin
            // read wins over write
            if (rd_pend) begin
              state     <= rd_addr;
              delay_cnt <= dly_w'(rom_cycle_len);
            end else if (wr_pend) begin
              state     <= wr_addr;
              delay_cnt <= dly_w'(rom_cycle_len);
            end
          end
        end
        rd_addr, wr_addr: begin
          delay_cnt <= delay_cnt - 1'b1;
          if (delay_cnt == '0) begin
            state <= (state == rd_addr) ? rd_end : wr_end;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  assign access = '{
    rd_active: (state == rd_addr),
    wr_active: (state == wr_addr),
    addr:      addr_q
  };

  // each access runs for its own pending request and only one request pends
  a_one_access: assert property (
    @(posedge CLK2) disable iff (!arst_n)
    !(rd_pend && wr_pend) && (!access.rd_active || rd_pend) && (!access.wr_active || wr_pend)
  );

  // ready only returns after the end state
  a_busy_in_access: assert property (
    @(posedge CLK2) disable iff (!arst_n)
    (state inside {rd_addr, wr_addr}) |-> !mcu_rdy
  );

endmodule

// ==== design/snes_bus_sampler.sv ====
module snes_bus_sampler #(
  parameter int dead_timeout = 96000
) (
  input  logic                     CLK2,
  input  logic                     arst_n,
  input  snes_bus_pkg::snes_addr_t snes_addr,
  input  logic                     snes_read_n,
  input  logic                     snes_romsel_n,
  input  logic                     snes_cpu_clk,
  input  snes_bus_pkg::snes_addr_t rom_mask,
  output snes_bus_pkg::snes_view_t view
);
  import snes_bus_pkg::*;

  // counter must reach dead_timeout + 1
  localparam int cnt_w = $clog2(dead_timeout + 2);
  localparam logic [cnt_w-1:0] dead_limit = cnt_w'(dead_timeout);

  ////////////////////////////////
  // input histories
  ////////////////////////////////

  logic [2:0]  read_hist;
  logic [6:0]  cpu_clk_hist;
  logic [5:0]  romsel_hist;
  snes_addr_t  addr_hist [6];

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      read_hist    <= '1;
      cpu_clk_hist <= '0;
      romsel_hist  <= '1;
    end else begin
      read_hist    <= {read_hist[1:0], snes_read_n};
      cpu_clk_hist <= {cpu_clk_hist[5:0], snes_cpu_clk};
      romsel_hist  <= {romsel_hist[4:0], snes_romsel_n};
    end
  end

  // address pipeline just follows the bus
  always_ff @(posedge CLK2) begin
    addr_hist[0] <= snes_addr;
    for (int i = 1; i < 6; i++) begin
      addr_hist[i] <= addr_hist[i-1];
    end
  end

  ////////////////////////////////
  // filtered levels and strobes
  ////////////////////////////////

  // two adjacent stages ANDed to reject single-sample glitches
  logic       read_n;
  logic       romsel_n;
  snes_addr_t addr_lvl;
  logic       cycle_start;
  logic       cycle_end;

  assign read_n   = read_hist[2] & read_hist[1];
  assign romsel_n = romsel_hist[5] & romsel_hist[4];
  assign addr_lvl = addr_hist[5] & addr_hist[4];

  // cpu clock rising after at least five low samples, and the reverse
  assign cycle_start = (cpu_clk_hist[6:1] == 6'b000001);
  assign cycle_end   = (cpu_clk_hist[6:1] == 6'b111110);

  logic rom_hit;
  logic free_strobe;

  // console only reads rom here
  assign rom_hit = ~romsel_n;

  // cycles outside rom leave the PSRAM free right after the clock rises
  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      free_strobe <= 1'b0;
    end else begin
      free_strobe <= cycle_start & ~rom_hit;
    end
  end

  ////////////////////////////////
  // dead console detection
  ////////////////////////////////

  logic [cnt_w-1:0] dead_cnt;
  logic             dead;
  logic             revive;

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      dead_cnt <= '0;
    end else if (cpu_clk_hist[1]) begin
      dead_cnt <= '0;
    end else if (dead_cnt <= dead_limit) begin
      // saturates one above the limit
      dead_cnt <= dead_cnt + 1'b1;
    end
  end

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      dead   <= 1'b1;
      revive <= 1'b0;
    end else begin
      revive <= 1'b0;
      if (cpu_clk_hist[1]) begin
        dead <= 1'b0;
        if (dead) begin
          revive <= 1'b1;
        end
      end else if (dead_cnt > dead_limit) begin
        dead <= 1'b1;
      end
    end
  end

  assign view = '{
    rom_addr:  addr_lvl & rom_mask,
    rom_hit:   rom_hit,
    read_n:    read_n,
    free_slot: cycle_end | free_strobe,
    dead:      dead,
    revive:    revive
  };

  // a console can only come back to life once per dead period
  a_revive_single: assert property (
    @(posedge CLK2) disable iff (!arst_n) revive |=> !revive
  );

endmodule

// ==== design/psram_pkg.sv ====
package psram_pkg;

  ////////////////////////////////
  // PSRAM widths
  ////////////////////////////////

  // one 16-bit PSRAM word
  typedef logic [15:0] psram_word_t;

  // word address, byte address bit 0 selects the lane
  typedef logic [22:0] psram_addr_t;

  ////////////////////////////////
  // MCU side
  ////////////////////////////////

  // request from the microcontroller, rrq and wrq are single pulses
  typedef struct packed {
    logic                   rrq;
    logic                   wrq;
    snes_bus_pkg::snes_addr_t addr;
    snes_bus_pkg::snes_byte_t wdata;
  } mcu_req_t;

  // access currently driven onto the PSRAM
  typedef struct packed {
    logic                   rd_active;
    logic                   wr_active;
    snes_bus_pkg::snes_addr_t addr;
  } mcu_access_t;

  // MCU access FSM
  typedef enum logic [2:0] {
    idle,
    rd_addr,
    rd_end,
    wr_addr,
    wr_end
  } access_state_t;

endpackage

// ==== design/snes_bus_pkg.sv ====
package snes_bus_pkg;

  ////////////////////////////////
  // console bus widths
  ////////////////////////////////

  // 24-bit console address, bank in bits 23:16
  typedef logic [23:0] snes_addr_t;

  // one byte on the console data bus
  typedef logic [7:0] snes_byte_t;

  ////////////////////////////////
  // sampled console view
  ////////////////////////////////

  // what the rest of the cartridge sees of the console after sampling
  typedef struct packed {
    // console address ANDed with the rom mask, byte granular
    snes_addr_t rom_addr;
    // romsel asserted for the current cycle
    logic       rom_hit;
    // active-low read, 2 cycles delayed
    logic       read_n;
    // PSRAM not needed by the console right now
    logic       free_slot;
    // CPU clock stopped long enough to count as dead
    logic       dead;
    // single pulse when a dead console starts clocking again
    logic       revive;
  } snes_view_t;

endpackage
